//--- common/mmu_pkg.sv
package mmu_pkg;

    // virtual and physical field widths
    localparam int VPN2_W     = 19;
    localparam int PFN_W      = 20;
    localparam int ASID_W     = 8;
    localparam int CATTR_W    = 3;
    localparam int PAGE_OFF_W = 12; // 4k pages, bit 12 picks odd/even

    // one half of a page pair
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CATTR_W-1:0] c;   // cache attribute
        logic               d;   // dirty, i.e. writable
        logic               v;
    } tlb_page_t;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         lo0;  // even page
        tlb_page_t         lo1;  // odd page
    } tlb_entry_t;

    // tlbp / tlbr / tlbwi / tlbwr
    typedef enum logic [2:0] {
        tlb_none,
        tlb_probe,
        tlb_read,
        tlb_write_index,
        tlb_write_random
    } tlb_op_e;

    // software visible cp0 registers
    typedef enum logic [2:0] {
        cp0_index,
        cp0_random,
        cp0_entrylo0,
        cp0_entrylo1,
        cp0_entryhi
    } cp0_reg_e;

endpackage

//--- common/tlb_cp0_if.sv
`timescale 1ns/10ps

interface tlb_cp0_if #(
    parameter int tlb_entries = 16
);
    localparam int idx_w = $clog2(tlb_entries);

    // write port
    logic                        we;
    logic [idx_w-1:0]            w_index;
    mmu_pkg::tlb_entry_t         w_entry;

    // indexed read, answered combinationally
    logic [idx_w-1:0]            r_index;
    mmu_pkg::tlb_entry_t         r_entry;

    // probe key and result
    logic [mmu_pkg::VPN2_W-1:0]  probe_vpn2;
    logic [mmu_pkg::ASID_W-1:0]  probe_asid;
    logic                        probe_hit;
    logic [idx_w-1:0]            probe_index;

    modport cp0 (
        output we, w_index, w_entry, r_index, probe_vpn2, probe_asid,
        input  r_entry, probe_hit, probe_index
    );

    modport tlb (
        input  we, w_index, w_entry, r_index, probe_vpn2, probe_asid,
        output r_entry, probe_hit, probe_index
    );

endinterface

//--- tlb/tlb_match.sv
`timescale 1ns/10ps

module tlb_match #(
    parameter int tlb_entries = 16
) (
    input  mmu_pkg::tlb_entry_t [tlb_entries-1:0] entries,
    input  logic [mmu_pkg::VPN2_W-1:0]            vpn2,
    input  logic [mmu_pkg::ASID_W-1:0]            asid,
    output logic                                  hit,
    output logic [$clog2(tlb_entries)-1:0]        hit_index
);

    localparam int idx_w = $clog2(tlb_entries);

    logic [tlb_entries-1:0] match_vec;

    // parallel compare, global entries ignore asid
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            match_vec[i] = (entries[i].vpn2 == vpn2) &&
                           (entries[i].g || (entries[i].asid == asid));
        end
    end

    // lowest index wins
    always_comb begin
        hit       = |match_vec;
        hit_index = '0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_index = idx_w'(i);
            end
        end
    end

endmodule

//--- tlb/tlb_array.sv
`timescale 1ns/10ps

module tlb_array #(
    parameter int tlb_entries = 16
) (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    tlb_cp0_if.tlb                                cp0,
    output mmu_pkg::tlb_entry_t [tlb_entries-1:0] entries
);

    // entry storage, cleared so every entry comes up invalid and non-global
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            entries <= '0;
        end else if (cp0.we) begin
            entries[cp0.w_index] <= cp0.w_entry;
        end
    end

    assign cp0.r_entry = entries[cp0.r_index]; // tlbr source

    // tlbp compares against the EntryHi key
    tlb_match #(
        .tlb_entries (tlb_entries)
    ) u_probe_match (
        .entries   (entries),
        .vpn2      (cp0.probe_vpn2),
        .asid      (cp0.probe_asid),
        .hit       (cp0.probe_hit),
        .hit_index (cp0.probe_index)
    );

endmodule

//--- tlb/tlb_translate.sv
`timescale 1ns/10ps

module tlb_translate #(
    parameter int tlb_entries = 16
) (
    input  logic                                  aclk,
    input  logic                                  rst_n,
    input  mmu_pkg::tlb_entry_t [tlb_entries-1:0] entries,
    input  logic [mmu_pkg::ASID_W-1:0]            cur_asid,
    input  logic [31:0]                           vaddr,
    input  logic                                  store,
    output logic [31:0]                           paddr,
    output logic                                  miss,
    output logic                                  invalid,
    output logic                                  modified,
    output logic [mmu_pkg::CATTR_W-1:0]           cattr
);

    localparam int idx_w = $clog2(tlb_entries);

    logic               hit;
    logic [idx_w-1:0]   hit_index;
    mmu_pkg::tlb_page_t sel;

    tlb_match #(
        .tlb_entries (tlb_entries)
    ) u_match (
        .entries   (entries),
        .vpn2      (vaddr[31 -: mmu_pkg::VPN2_W]),
        .asid      (cur_asid),
        .hit       (hit),
        .hit_index (hit_index)
    );

    // bit 12 selects the odd page
    assign sel = vaddr[mmu_pkg::PAGE_OFF_W] ? entries[hit_index].lo1
                                            : entries[hit_index].lo0;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            miss     <= 1'b0;
            invalid  <= 1'b0;
            modified <= 1'b0;
        end else begin
            miss     <= !hit;
            invalid  <= hit && !sel.v;
            modified <= hit && store && sel.v && !sel.d; // store to clean page
        end
    end

    // zero on miss
    always_ff @(posedge aclk) begin
        paddr <= hit ? {sel.pfn, vaddr[mmu_pkg::PAGE_OFF_W-1:0]} : '0;
        cattr <= hit ? sel.c : '0;
    end

endmodule

//--- cp0/cp0_tlb_regs.sv
`timescale 1ns/10ps

module cp0_tlb_regs #(
    parameter int tlb_entries = 16
) (
    input  logic                        aclk,
    input  logic                        rst_n,
    input  mmu_pkg::tlb_op_e            tlb_op,
    input  logic                        cp0_wr_en,
    input  mmu_pkg::cp0_reg_e           cp0_wr_sel,
    input  logic [31:0]                 cp0_wr_data,
    input  mmu_pkg::cp0_reg_e           cp0_rd_sel,
    output logic [31:0]                 cp0_rd_data,
    output logic [mmu_pkg::ASID_W-1:0]  cur_asid,
    tlb_cp0_if.cp0                      tlb
);

    localparam int idx_w = $clog2(tlb_entries);

    logic                       index_p;
    logic [idx_w-1:0]           index_val;
    logic [idx_w-1:0]           random_val;
    logic [mmu_pkg::VPN2_W-1:0] ehi_vpn2;
    logic [mmu_pkg::ASID_W-1:0] ehi_asid;
    mmu_pkg::tlb_page_t         lo0;
    mmu_pkg::tlb_page_t         lo1;
    logic                       lo0_g;
    logic                       lo1_g;

    // EntryLo layout: pfn 25:6, c 5:3, d 2, v 1, g 0
    function automatic mmu_pkg::tlb_page_t unpack_lo(input logic [31:0] w);
        return '{pfn: w[25:6], c: w[5:3], d: w[2], v: w[1]};
    endfunction

    function automatic logic [31:0] pack_lo(input mmu_pkg::tlb_page_t pg, input logic g);
        return {6'b0, pg.pfn, pg.c, pg.d, pg.v, g};
    endfunction

    // software write has priority over an op in the same cycle
    assign tlb.we = !cp0_wr_en &&
                    (tlb_op == mmu_pkg::tlb_write_index ||
                     tlb_op == mmu_pkg::tlb_write_random);
    assign tlb.w_index = (tlb_op == mmu_pkg::tlb_write_random) ? random_val : index_val;
    assign tlb.w_entry = '{vpn2: ehi_vpn2, asid: ehi_asid, g: lo0_g & lo1_g,
                           lo0: lo0, lo1: lo1};
    assign tlb.r_index    = index_val;
    assign tlb.probe_vpn2 = ehi_vpn2;
    assign tlb.probe_asid = ehi_asid;

    assign cur_asid = ehi_asid;

    // free running, wraps to all ones after 0
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            random_val <= '1;
        end else begin
            random_val <= random_val - 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            index_p   <= 1'b0;
            index_val <= '0;
            ehi_vpn2  <= '0;
            ehi_asid  <= '0;
            lo0       <= '0;
            lo1       <= '0;
            lo0_g     <= 1'b0;
            lo1_g     <= 1'b0;
        end else if (cp0_wr_en) begin
            case (cp0_wr_sel)
                mmu_pkg::cp0_index: begin
                    index_p   <= cp0_wr_data[31];
                    index_val <= cp0_wr_data[idx_w-1:0];
                end
                mmu_pkg::cp0_entrylo0: begin
                    lo0   <= unpack_lo(cp0_wr_data);
                    lo0_g <= cp0_wr_data[0];
                end
                mmu_pkg::cp0_entrylo1: begin
                    lo1   <= unpack_lo(cp0_wr_data);
                    lo1_g <= cp0_wr_data[0];
                end
                mmu_pkg::cp0_entryhi: begin
                    ehi_vpn2 <= cp0_wr_data[31:13];
                    ehi_asid <= cp0_wr_data[7:0];
                end
                default: ; // random is read only
            endcase
        end else begin
            case (tlb_op)
                mmu_pkg::tlb_probe: begin
                    index_p <= !tlb.probe_hit;
                    if (tlb.probe_hit) begin
                        index_val <= tlb.probe_index;
                    end
                end
                mmu_pkg::tlb_read: begin
                    ehi_vpn2 <= tlb.r_entry.vpn2;
                    ehi_asid <= tlb.r_entry.asid;
                    lo0      <= tlb.r_entry.lo0;
                    lo1      <= tlb.r_entry.lo1;
                    lo0_g    <= tlb.r_entry.g;   // g shows up in both halves
                    lo1_g    <= tlb.r_entry.g;
                end
                default: ; // writes go out on tlb.we
            endcase
        end
    end

    always_comb begin
        case (cp0_rd_sel)
            mmu_pkg::cp0_index:    cp0_rd_data = {index_p, {(31-idx_w){1'b0}}, index_val};
            mmu_pkg::cp0_random:   cp0_rd_data = {{(32-idx_w){1'b0}}, random_val};
            mmu_pkg::cp0_entrylo0: cp0_rd_data = pack_lo(lo0, lo0_g);
            mmu_pkg::cp0_entrylo1: cp0_rd_data = pack_lo(lo1, lo1_g);
            mmu_pkg::cp0_entryhi:  cp0_rd_data = {ehi_vpn2, 5'b0, ehi_asid};
            default:               cp0_rd_data = '0;
        endcase
    end

endmodule

//--- verilog/mmu_top.sv
`timescale 1ns/10ps

module mmu_top #(
    parameter int tlb_entries = 16
) (
    input  logic                          aclk,
    input  logic                          rst_n,

    input  mmu_pkg::tlb_op_e              tlb_op,

    // software access to the cp0 registers
    input  logic                          cp0_wr_en,
    input  mmu_pkg::cp0_reg_e             cp0_wr_sel,
    input  logic [31:0]                   cp0_wr_data,
    input  mmu_pkg::cp0_reg_e             cp0_rd_sel,
    output logic [31:0]                   cp0_rd_data,

    // instruction fetch lookup
    input  logic [31:0]                   fetch_vaddr,
    output logic [31:0]                   fetch_paddr,
    output logic                          fetch_miss,
    output logic                          fetch_invalid,
    output logic [mmu_pkg::CATTR_W-1:0]   fetch_cattr,

    // data lookup
    input  logic [31:0]                   data_vaddr,
    input  logic                          data_store,
    output logic [31:0]                   data_paddr,
    output logic                          data_miss,
    output logic                          data_invalid,
    output logic                          data_modified,
    output logic [mmu_pkg::CATTR_W-1:0]   data_cattr
);

    mmu_pkg::tlb_entry_t [tlb_entries-1:0] entries;
    logic [mmu_pkg::ASID_W-1:0]            cur_asid;

    tlb_cp0_if #(.tlb_entries(tlb_entries)) u_tlb_cp0_if ();

    cp0_tlb_regs #(
        .tlb_entries (tlb_entries)
    ) u_cp0_tlb_regs (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .tlb_op      (tlb_op),
        .cp0_wr_en   (cp0_wr_en),
        .cp0_wr_sel  (cp0_wr_sel),
        .cp0_wr_data (cp0_wr_data),
        .cp0_rd_sel  (cp0_rd_sel),
        .cp0_rd_data (cp0_rd_data),
        .cur_asid    (cur_asid),
        .tlb         (u_tlb_cp0_if.cp0)
    );

    tlb_array #(
        .tlb_entries (tlb_entries)
    ) u_tlb_array (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .cp0     (u_tlb_cp0_if.tlb),
        .entries (entries)
    );

    tlb_translate #(
        .tlb_entries (tlb_entries)
    ) u_fetch_xlate (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .entries  (entries),
        .cur_asid (cur_asid),
        .vaddr    (fetch_vaddr),
        .store    (1'b0),          // fetch never stores
        .paddr    (fetch_paddr),
        .miss     (fetch_miss),
        .invalid  (fetch_invalid),
        .modified (),
        .cattr    (fetch_cattr)
    );

    tlb_translate #(
        .tlb_entries (tlb_entries)
    ) u_data_xlate (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .entries  (entries),
        .cur_asid (cur_asid),
        .vaddr    (data_vaddr),
        .store    (data_store),
        .paddr    (data_paddr),
        .miss     (data_miss),
        .invalid  (data_invalid),
        .modified (data_modified),
        .cattr    (data_cattr)
    );

endmodule

//--- verification/tb_mmu_top.sv
`timescale 1ns/10ps

module tb_mmu_top;

    localparam int N         = 16;
    localparam int IW        = $clog2(N);
    localparam int RAND_ROWS = 200;

    typedef enum logic [1:0] {k_wr, k_op, k_rd, k_lk} kind_e;

    typedef struct packed {
        kind_e                        kind;
        mmu_pkg::tlb_op_e             op;
        mmu_pkg::cp0_reg_e            sel;
        logic [31:0]                  data;   // write data or vaddr
        logic                         store;
        logic                         has_exp;
        logic [31:0]                  exp;    // read word or paddr
        logic [mmu_pkg::CATTR_W-1:0]  exp_c;
        logic [2:0]                   exp_fl; // miss, invalid, modified
    } row_t;

    logic                         aclk;
    logic                         rst_n;
    mmu_pkg::tlb_op_e             tlb_op;
    logic                         cp0_wr_en;
    mmu_pkg::cp0_reg_e            cp0_wr_sel;
    logic [31:0]                  cp0_wr_data;
    mmu_pkg::cp0_reg_e            cp0_rd_sel;
    logic [31:0]                  cp0_rd_data;
    logic [31:0]                  fetch_vaddr;
    logic [31:0]                  fetch_paddr;
    logic                         fetch_miss;
    logic                         fetch_invalid;
    logic [mmu_pkg::CATTR_W-1:0]  fetch_cattr;
    logic [31:0]                  data_vaddr;
    logic                         data_store;
    logic [31:0]                  data_paddr;
    logic                         data_miss;
    logic                         data_invalid;
    logic                         data_modified;
    logic [mmu_pkg::CATTR_W-1:0]  data_cattr;

    row_t table_q[$];
    int   cycles;
    int   limit;
    int   seed;

    // reference model state
    mmu_pkg::tlb_entry_t m_ent [N];
    logic                m_p;
    logic [IW-1:0]       m_idx;
    logic [IW-1:0]       m_rand;
    logic [18:0]         m_vpn2;
    logic [7:0]          m_asid;
    logic [31:0]         m_lo0;
    logic [31:0]         m_lo1;

    // lookup waiting for its registered result
    logic                        pend;
    row_t                        pend_row;
    logic [31:0]                 pend_pa;
    logic [mmu_pkg::CATTR_W-1:0] pend_c;
    logic [2:0]                  pend_fl;
    logic [2:0]                  pend_fl_fetch;

    mmu_top #(.tlb_entries(N)) u_mmu_top (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic fail(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input mmu_pkg::cp0_reg_e sel, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            fail($sformatf("cp0 %s read 0x%08h, expected 0x%08h", sel.name(), got, exp));
    endtask

    task automatic check_xlate(input string port, input logic [31:0] pa,
                               input logic [mmu_pkg::CATTR_W-1:0] c, input logic [2:0] fl,
                               input logic [31:0] exp_pa,
                               input logic [mmu_pkg::CATTR_W-1:0] exp_c,
                               input logic [2:0] exp_fl);
        if (pa !== exp_pa || c !== exp_c || fl !== exp_fl)
            fail($sformatf("%s paddr 0x%08h c %0d flags %b, expected 0x%08h c %0d flags %b",
                           port, pa, c, fl, exp_pa, exp_c, exp_fl));
    endtask

    function automatic mmu_pkg::tlb_page_t lo_fields(input logic [31:0] w);
        mmu_pkg::tlb_page_t pg;
        pg.pfn = w[25:6];
        pg.c   = w[5:3];
        pg.d   = w[2];
        pg.v   = w[1];
        return pg;
    endfunction

    function automatic int find_match(input logic [18:0] vpn2, input logic [7:0] asid);
        int hit_i;
        hit_i = -1;
        for (int i = N - 1; i >= 0; i--)
            if (m_ent[i].vpn2 == vpn2 && (m_ent[i].g || m_ent[i].asid == asid)) hit_i = i;
        return hit_i;
    endfunction

    function automatic logic [31:0] model_reg(input mmu_pkg::cp0_reg_e sel);
        case (sel)
            mmu_pkg::cp0_index:    return {m_p, {(31-IW){1'b0}}, m_idx};
            mmu_pkg::cp0_random:   return {{(32-IW){1'b0}}, m_rand};
            mmu_pkg::cp0_entrylo0: return m_lo0;
            mmu_pkg::cp0_entrylo1: return m_lo1;
            mmu_pkg::cp0_entryhi:  return {m_vpn2, 5'b0, m_asid};
            default:               return 32'h0;
        endcase
    endfunction

    task automatic model_lookup(input logic [31:0] va, input logic st, output logic [31:0] pa,
                                output logic [mmu_pkg::CATTR_W-1:0] c, output logic [2:0] fl);
        int                 hit_i;
        mmu_pkg::tlb_page_t pg;
        hit_i = find_match(va[31:13], m_asid);
        if (hit_i < 0) begin
            pa = 32'h0;
            c  = '0;
            fl = 3'b100;
        end else begin
            pg = va[12] ? m_ent[hit_i].lo1 : m_ent[hit_i].lo0;
            pa = {pg.pfn, va[11:0]};
            c  = pg.c;
            fl = {1'b0, !pg.v, st && pg.v && !pg.d};
        end
    endtask

    // state change at the edge that ends the row
    task automatic model_step(input row_t r);
        mmu_pkg::tlb_entry_t e;
        int                  hit_i;
        e = '{vpn2: m_vpn2, asid: m_asid, g: m_lo0[0] & m_lo1[0],
              lo0: lo_fields(m_lo0), lo1: lo_fields(m_lo1)};
        if (r.kind == k_wr) begin
            case (r.sel)
                mmu_pkg::cp0_index: begin
                    m_p   = r.data[31];
                    m_idx = r.data[IW-1:0];
                end
                mmu_pkg::cp0_entrylo0: m_lo0 = r.data & 32'h03ff_ffff;
                mmu_pkg::cp0_entrylo1: m_lo1 = r.data & 32'h03ff_ffff;
                mmu_pkg::cp0_entryhi: begin
                    m_vpn2 = r.data[31:13];
                    m_asid = r.data[7:0];
                end
                default: ;
            endcase
        end else if (r.kind == k_op) begin
            case (r.op)
                mmu_pkg::tlb_probe: begin
                    hit_i = find_match(m_vpn2, m_asid);
                    m_p   = (hit_i < 0);
                    if (hit_i >= 0) m_idx = IW'(hit_i);
                end
                mmu_pkg::tlb_read: begin
                    e      = m_ent[m_idx];
                    m_vpn2 = e.vpn2;
                    m_asid = e.asid;
                    m_lo0  = {6'b0, e.lo0.pfn, e.lo0.c, e.lo0.d, e.lo0.v, e.g};
                    m_lo1  = {6'b0, e.lo1.pfn, e.lo1.c, e.lo1.d, e.lo1.v, e.g};
                end
                mmu_pkg::tlb_write_index:  m_ent[m_idx]  = e;
                mmu_pkg::tlb_write_random: m_ent[m_rand] = e;
                default: ;
            endcase
        end
        m_rand = (m_rand == 0) ? IW'(N - 1) : m_rand - 1'b1;
    endtask

    task automatic add_row(input kind_e k, input mmu_pkg::tlb_op_e op,
                           input mmu_pkg::cp0_reg_e sel, input logic [31:0] data,
                           input logic st, input logic has, input logic [31:0] exp,
                           input logic [2:0] c, input logic [2:0] fl);
        row_t r;
        r = '{kind: k, op: op, sel: sel, data: data, store: st, has_exp: has,
              exp: exp, exp_c: c, exp_fl: fl};
        table_q.push_back(r);
    endtask

    task automatic add_wr(input mmu_pkg::cp0_reg_e sel, input logic [31:0] data);
        add_row(k_wr, mmu_pkg::tlb_none, sel, data, 1'b0, 1'b0, 32'h0, 3'd0, 3'd0);
    endtask

    task automatic add_op(input mmu_pkg::tlb_op_e op);
        add_row(k_op, op, mmu_pkg::cp0_random, 32'h0, 1'b0, 1'b0, 32'h0, 3'd0, 3'd0);
    endtask

    task automatic add_rd(input mmu_pkg::cp0_reg_e sel, input logic has, input logic [31:0] exp);
        add_row(k_rd, mmu_pkg::tlb_none, sel, 32'h0, 1'b0, has, exp, 3'd0, 3'd0);
    endtask

    task automatic add_lk(input logic [31:0] va, input logic st, input logic [31:0] pa,
                          input logic [2:0] c, input logic [2:0] fl);
        add_row(k_lk, mmu_pkg::tlb_none, mmu_pkg::cp0_index, va, st, 1'b1, pa, c, fl);
    endtask

    task automatic build_table();
        add_rd(mmu_pkg::cp0_random, 1'b1, 32'(N - 1));
        add_rd(mmu_pkg::cp0_index, 1'b1, 32'h0);
        add_rd(mmu_pkg::cp0_entrylo0, 1'b1, 32'h0);
        add_rd(mmu_pkg::cp0_entrylo1, 1'b1, 32'h0);
        add_rd(mmu_pkg::cp0_entryhi, 1'b1, 32'h0);
        add_lk(32'h0000_0123, 1'b0, 32'h0000_0123, 3'd0, 3'b010); // zero entry reads invalid
        // entry 2 with asid 5
        add_wr(mmu_pkg::cp0_index, 32'h2);
        add_wr(mmu_pkg::cp0_entryhi, 32'h2468_a005);
        add_wr(mmu_pkg::cp0_entrylo0, 32'h02af_379e);
        add_wr(mmu_pkg::cp0_entrylo1, 32'h0155_5552);
        add_op(mmu_pkg::tlb_write_index);
        add_lk(32'h2468_a456, 1'b0, 32'habcd_e456, 3'd3, 3'b000);
        add_lk(32'h2468_b456, 1'b0, 32'h5555_5456, 3'd2, 3'b000);
        add_lk(32'h1000_0000, 1'b0, 32'h0, 3'd0, 3'b100);
        // entry 3 has an invalid even page and a clean odd page
        add_wr(mmu_pkg::cp0_index, 32'h3);
        add_wr(mmu_pkg::cp0_entryhi, 32'h00ee_e005);
        add_wr(mmu_pkg::cp0_entrylo0, 32'h0044_4450);
        add_wr(mmu_pkg::cp0_entrylo1, 32'h0044_4452);
        add_op(mmu_pkg::tlb_write_index);
        add_lk(32'h00ee_e010, 1'b0, 32'h1111_1010, 3'd2, 3'b010);
        add_lk(32'h00ee_f010, 1'b1, 32'h1111_1010, 3'd2, 3'b001);
        add_lk(32'h00ee_f010, 1'b0, 32'h1111_1010, 3'd2, 3'b000);
        // entry 4 global
        add_wr(mmu_pkg::cp0_index, 32'h4);
        add_wr(mmu_pkg::cp0_entryhi, 32'h8000_0005);
        add_wr(mmu_pkg::cp0_entrylo0, 32'h0003_c01f);
        add_wr(mmu_pkg::cp0_entrylo1, 32'h0003_c01f);
        add_op(mmu_pkg::tlb_write_index);
        add_wr(mmu_pkg::cp0_entryhi, 32'h0000_0009);
        add_lk(32'h2468_a456, 1'b0, 32'h0, 3'd0, 3'b100);
        add_lk(32'h8000_0abc, 1'b0, 32'h00f0_0abc, 3'd3, 3'b000);
        // probe hit and probe miss then read back
        add_wr(mmu_pkg::cp0_entryhi, 32'h2468_a005);
        add_op(mmu_pkg::tlb_probe);
        add_rd(mmu_pkg::cp0_index, 1'b1, 32'h0000_0002);
        add_wr(mmu_pkg::cp0_entryhi, 32'h1234_0005);
        add_op(mmu_pkg::tlb_probe);
        add_rd(mmu_pkg::cp0_index, 1'b1, 32'h8000_0002);
        add_op(mmu_pkg::tlb_read);
        add_rd(mmu_pkg::cp0_entryhi, 1'b1, 32'h2468_a005);
        add_rd(mmu_pkg::cp0_entrylo0, 1'b1, 32'h02af_379e);
        add_rd(mmu_pkg::cp0_entrylo1, 1'b1, 32'h0155_5552);
        add_wr(mmu_pkg::cp0_index, 32'h4);
        add_op(mmu_pkg::tlb_read);
        add_rd(mmu_pkg::cp0_entryhi, 1'b1, 32'h8000_0005);
        add_rd(mmu_pkg::cp0_entrylo0, 1'b1, 32'h0003_c01f);
        // tlbwr lands on the Random value read in the same cycle
        add_wr(mmu_pkg::cp0_entryhi, 32'h6000_0005);
        add_wr(mmu_pkg::cp0_entrylo0, 32'h0004_0006);
        add_wr(mmu_pkg::cp0_entrylo1, 32'h0004_0006);
        add_op(mmu_pkg::tlb_write_random);
        add_op(mmu_pkg::tlb_probe);
        add_rd(mmu_pkg::cp0_index, 1'b0, 32'h0);
        add_op(mmu_pkg::tlb_read);
        add_rd(mmu_pkg::cp0_entryhi, 1'b1, 32'h6000_0005);
    endtask

    task automatic add_random_rows();
        logic [31:0] v;
        logic [31:0] w;
        for (int i = 0; i < RAND_ROWS; i++) begin
            v = $random(seed);
            w = $random(seed);
            w[31:13] = {17'h0, w[14:13]};  // few vpn2 values so lookups hit
            case (v % 4)
                0: add_wr(mmu_pkg::cp0_reg_e'(3'((v >> 4) % 5)),
                          ((v >> 4) % 5 == 4) ? (w & 32'hffff_e003) : w);
                1: add_op(mmu_pkg::tlb_op_e'(3'((v >> 4) % 5)));
                2: add_rd(mmu_pkg::cp0_reg_e'(3'((v >> 4) % 5)), 1'b0, 32'h0);
                default: add_row(k_lk, mmu_pkg::tlb_none, mmu_pkg::cp0_index, w, v[8],
                                 1'b0, 32'h0, 3'd0, 3'd0);
            endcase
        end
    endtask

    task automatic check_pending();
        if (pend) begin
            check_xlate("data", data_paddr, data_cattr,
                        {data_miss, data_invalid, data_modified}, pend_pa, pend_c, pend_fl);
            check_xlate("fetch", fetch_paddr, fetch_cattr,
                        {fetch_miss, fetch_invalid, 1'b0}, pend_pa, pend_c, pend_fl_fetch);
            if (pend_row.has_exp)
                check_xlate("data", data_paddr, data_cattr,
                            {data_miss, data_invalid, data_modified},
                            pend_row.exp, pend_row.exp_c, pend_row.exp_fl);
        end
        pend = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0]                 pa;
        logic [mmu_pkg::CATTR_W-1:0] c;
        logic [2:0]                  fl;
        pa        = 32'h0;
        c         = '0;
        fl        = 3'b000;
        cp0_wr_en = 1'b0;
        tlb_op    = mmu_pkg::tlb_none;
        case (r.kind)
            k_wr: begin
                cp0_wr_en   = 1'b1;
                cp0_wr_sel  = r.sel;
                cp0_wr_data = r.data;
            end
            k_op: begin
                tlb_op     = r.op;
                cp0_rd_sel = mmu_pkg::cp0_random;
            end
            k_rd: begin
                cp0_rd_sel = r.sel;
            end
            default: begin
                fetch_vaddr = r.data;
                data_vaddr  = r.data;
                data_store  = r.store;
                model_lookup(r.data, r.store, pa, c, fl);
            end
        endcase
        // the previous result must still hold after a new address goes in
        #1 check_pending();
        case (r.kind)
            k_op: begin
                check_word(mmu_pkg::cp0_random, cp0_rd_data,
                           model_reg(mmu_pkg::cp0_random));
            end
            k_rd: begin
                check_word(r.sel, cp0_rd_data, model_reg(r.sel));
                if (r.has_exp) check_word(r.sel, cp0_rd_data, r.exp);
            end
            k_lk: begin
                pend          = 1'b1;
                pend_row      = r;
                pend_pa       = pa;
                pend_c        = c;
                pend_fl       = fl;
                pend_fl_fetch = {fl[2:1], 1'b0};
            end
            default: ;
        endcase
        @(posedge aclk);
        model_step(r);
        @(negedge aclk);
    endtask

    initial begin
        seed        = 32'h925f_11cd;
        cycles      = 0;
        limit       = 0;
        pend        = 1'b0;
        rst_n       = 1'b0;
        tlb_op      = mmu_pkg::tlb_none;
        cp0_wr_en   = 1'b0;
        cp0_wr_sel  = mmu_pkg::cp0_index;
        cp0_wr_data = 32'h0;
        cp0_rd_sel  = mmu_pkg::cp0_index;
        fetch_vaddr = 32'h0;
        data_vaddr  = 32'h0;
        data_store  = 1'b0;
        build_table();
        add_random_rows();
        limit = 2 * table_q.size() + RAND_ROWS + 100;
        for (int i = 0; i < N; i++) m_ent[i] = '0;
        m_p    = 1'b0;
        m_idx  = '0;
        m_rand = IW'(N - 1);
        m_vpn2 = '0;
        m_asid = '0;
        m_lo0  = 32'h0;
        m_lo1  = 32'h0;
        repeat (16) @(negedge aclk);
        rst_n = 1'b1;
        foreach (table_q[i]) apply_row(table_q[i]);
        check_pending();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- tb.f
common/mmu_pkg.sv
common/tlb_cp0_if.sv
tlb/tlb_match.sv
tlb/tlb_array.sv
tlb/tlb_translate.sv
cp0/cp0_tlb_regs.sv
verilog/mmu_top.sv
verification/tb_mmu_top.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_mmu_top"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_mmu_top \
		--Mdir $(OBJ_DIR) -o Vtb_mmu_top
	./$(OBJ_DIR)/Vtb_mmu_top

clean:
	rm -rf $(OBJ_DIR)
